/* sim.f */
tiny_isa_pkg.sv
mem_map_pkg.sv
tiny_core.sv
dp_ram.sv
mm_ram.sv
tb_subsystem.sv
tb_top.sv

/* Bender.yml */
package:
  name: tiny_core_subsystem

sources:
  - tiny_isa_pkg.sv
  - mem_map_pkg.sv
  - tiny_core.sv
  - dp_ram.sv
  - mm_ram.sv
  - tb_subsystem.sv
  - target: test
    files:
      - tb_top.sv

/* tb_top.sv */
// Testbench for the tiny core test subsystem.
// Each table entry is a small program that is written into RAM through the
// loader port. The core then runs it until it sleeps, and the exit value,
// the pass/fail flags and the stdout characters are compared with the entry.

`timescale 1ns/1ps

module tb_top import tiny_isa_pkg::*, mem_map_pkg::*; ();

  localparam int NUM_TESTS   = 7;
  localparam int PROG_WORDS  = 16;
  // the longest loop in the table is 3 instructions run 5 times
  localparam int LOOP_INSTRS = 3;
  localparam int LOOP_ITERS  = 5;
  localparam int MARGIN      = 500;
  localparam int TEST_CYCLES = PROG_WORDS + 5 * LOOP_INSTRS * LOOP_ITERS + MARGIN;
  localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        fetch_enable_i;
  logic        load_we_i;
  logic [31:0] load_addr_i;
  logic [31:0] load_data_i;

  logic        stdout_valid_o;
  logic [7:0]  stdout_char_o;
  logic        exit_valid_o;
  logic [31:0] exit_value_o;
  logic        tests_passed_o;
  logic        tests_failed_o;
  logic        core_sleep_o;

  // test table
  string       test_name [NUM_TESTS];
  logic [31:0] prog [NUM_TESTS][PROG_WORDS];
  logic        exp_exit_valid [NUM_TESTS];
  logic [31:0] exp_exit_value [NUM_TESTS];
  logic        exp_passed [NUM_TESTS];
  logic        exp_failed [NUM_TESTS];
  string       exp_stdout [NUM_TESTS];
  int          exp_stdout_len [NUM_TESTS];

  logic [7:0]  got_chars [$];
  int          err_count = 0;
  int          cycle_count = 0;

  tb_subsystem #(
    .RAM_ADDR_WIDTH(12),
    .BOOT_ADDR     (32'h0)
  ) uut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fetch_enable_i(fetch_enable_i),
    .load_we_i     (load_we_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .stdout_valid_o(stdout_valid_o),
    .stdout_char_o (stdout_char_o),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o),
    .tests_passed_o(tests_passed_o),
    .tests_failed_o(tests_failed_o),
    .core_sleep_o  (core_sleep_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the core did not go to sleep within %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  // each stdout_valid_o pulse lasts one cycle and carries one character
  always @(negedge clk_i) begin
    if (stdout_valid_o) got_chars.push_back(stdout_char_o);
  end

  function automatic logic [31:0] encode_instr(opcode_e op, int rd, int rs1, int rs2, int imm);
    return {op, rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]};
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) else begin
      $display("ERR %s exp=%h got=%h", name, exp, got);
      err_count++;
    end
  endtask

  task automatic set_expect(input int t, input string name, input logic ev,
                            input logic [31:0] value, input logic pass,
                            input logic fail, input string str, input int len);
    test_name[t]      = name;
    exp_exit_valid[t] = ev;
    exp_exit_value[t] = value;
    exp_passed[t]     = pass;
    exp_failed[t]     = fail;
    exp_stdout[t]     = str;
    exp_stdout_len[t] = len;
  endtask

  task automatic build_table();
    foreach (prog[t, i]) prog[t][i] = 32'h0;

    // an all-zero image is a single OP_HALT
    set_expect(0, "halt", 1'b0, 32'h0, 1'b0, 1'b0, "", 0);

    // 100 + -7 = 93, 100 - -7 = 107, 93 ^ 107 = 0x36, then + 0x1000
    prog[1][0]  = encode_instr(OP_LI, 1, 0, 0, 100);
    prog[1][1]  = encode_instr(OP_LI, 2, 0, 0, -7);
    prog[1][2]  = encode_instr(OP_ADD, 3, 1, 2, 0);
    prog[1][3]  = encode_instr(OP_SUB, 4, 1, 2, 0);
    prog[1][4]  = encode_instr(OP_XOR, 5, 3, 4, 0);
    prog[1][5]  = encode_instr(OP_ADDI, 5, 5, 0, 16'h1000);
    prog[1][6]  = encode_instr(OP_LW, 6, 0, 0, 40);
    prog[1][7]  = encode_instr(OP_SW, 5, 6, 0, 0);
    prog[1][10] = 32'h2000_0000;
    set_expect(1, "alu", 1'b1, 32'h0000_1036, 1'b0, 1'b0, "", 0);

    // byte 0xab lands in lane 2 which is bits 23:16 of the stored word
    prog[2][0]  = encode_instr(OP_LI, 1, 0, 0, 16'h0100);
    prog[2][1]  = encode_instr(OP_LW, 2, 0, 0, 40);
    prog[2][2]  = encode_instr(OP_SW, 2, 1, 0, 0);
    prog[2][3]  = encode_instr(OP_LI, 3, 0, 0, 16'h00ab);
    prog[2][4]  = encode_instr(OP_SB, 3, 1, 0, 2);
    prog[2][5]  = encode_instr(OP_LW, 4, 1, 0, 0);
    prog[2][6]  = encode_instr(OP_LW, 5, 0, 0, 44);
    prog[2][7]  = encode_instr(OP_SW, 4, 5, 0, 0);
    prog[2][10] = 32'h1122_3344;
    prog[2][11] = 32'h2000_0000;
    set_expect(2, "load_store", 1'b1, 32'h11ab_3344, 1'b0, 1'b0, "", 0);

    // sum of 5 down to 1, and the BEQ jumps over the overwrite
    prog[3][0]  = encode_instr(OP_LI, 1, 0, 0, 5);
    prog[3][1]  = encode_instr(OP_LI, 2, 0, 0, 0);
    prog[3][2]  = encode_instr(OP_ADD, 2, 2, 1, 0);
    prog[3][3]  = encode_instr(OP_ADDI, 1, 1, 0, -1);
    prog[3][4]  = encode_instr(OP_BNE, 0, 1, 0, -2);
    prog[3][5]  = encode_instr(OP_BEQ, 0, 0, 0, 2);
    prog[3][6]  = encode_instr(OP_LI, 2, 0, 0, 16'h7777);
    prog[3][7]  = encode_instr(OP_LW, 3, 0, 0, 44);
    prog[3][8]  = encode_instr(OP_SW, 2, 3, 0, 0);
    prog[3][11] = 32'h2000_0000;
    set_expect(3, "branch", 1'b1, 32'h0000_000f, 1'b0, 1'b0, "", 0);

    // the exit base is twice the stdout base and CTRL sits 4 bytes above it
    prog[4][0]  = encode_instr(OP_LW, 1, 0, 0, 56);
    prog[4][1]  = encode_instr(OP_LI, 2, 0, 0, 8'h4f);
    prog[4][2]  = encode_instr(OP_SW, 2, 1, 0, 0);
    prog[4][3]  = encode_instr(OP_LI, 2, 0, 0, 8'h4b);
    prog[4][4]  = encode_instr(OP_SW, 2, 1, 0, 0);
    prog[4][5]  = encode_instr(OP_LI, 2, 0, 0, 8'h21);
    prog[4][6]  = encode_instr(OP_SW, 2, 1, 0, 0);
    prog[4][7]  = encode_instr(OP_LI, 2, 0, 0, 8'h0a);
    prog[4][8]  = encode_instr(OP_SW, 2, 1, 0, 0);
    prog[4][9]  = encode_instr(OP_ADD, 3, 1, 1, 0);
    prog[4][10] = encode_instr(OP_LW, 4, 0, 0, 60);
    prog[4][11] = encode_instr(OP_SW, 4, 3, 0, 4);
    prog[4][14] = STDOUT_ADDR;
    prog[4][15] = PASS_MAGIC;
    set_expect(4, "periph_pass", 1'b0, 32'h0, 1'b1, 1'b0, "OK!\n", 4);

    prog[5][0]  = encode_instr(OP_LI, 1, 0, 0, FAIL_CODE[15:0]);
    prog[5][1]  = encode_instr(OP_LW, 3, 0, 0, 60);
    prog[5][2]  = encode_instr(OP_SW, 1, 3, 0, 4);
    prog[5][15] = EXIT_VALUE_ADDR;
    set_expect(5, "periph_fail", 1'b0, 32'h0, 1'b0, 1'b1, "", 0);

    // opcode 15 is unused, so the store after it must never happen
    prog[6][0]  = encode_instr(OP_LI, 1, 0, 0, 16'h0055);
    prog[6][1]  = encode_instr(OP_LW, 3, 0, 0, 60);
    prog[6][2]  = 32'hf000_0000;
    prog[6][3]  = encode_instr(OP_SW, 1, 3, 0, 0);
    prog[6][15] = EXIT_VALUE_ADDR;
    set_expect(6, "illegal", 1'b0, 32'h0, 1'b0, 1'b0, "", 0);
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_n_i        <= 1'b0;
    fetch_enable_i <= 1'b0;
    load_we_i      <= 1'b0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
  endtask

  task automatic check_reset_state();
    check_val("stdout_valid_o", 32'h0, 32'(stdout_valid_o));
    check_val("stdout_char_o", 32'h0, 32'(stdout_char_o));
    check_val("exit_valid_o", 32'h0, 32'(exit_valid_o));
    check_val("exit_value_o", 32'h0, exit_value_o);
    check_val("tests_passed_o", 32'h0, 32'(tests_passed_o));
    check_val("tests_failed_o", 32'h0, 32'(tests_failed_o));
    check_val("core_sleep_o", 32'h0, 32'(core_sleep_o));
  endtask

  task automatic load_program(input int t);
    for (int i = 0; i < PROG_WORDS; i++) begin
      @(posedge clk_i);
      load_we_i   <= 1'b1;
      load_addr_i <= 32'(4 * i);
      load_data_i <= prog[t][i];
    end
    @(posedge clk_i);
    load_we_i <= 1'b0;
  endtask

  task automatic check_results(input int t);
    int n;
    check_val("core_sleep_o", 32'h1, 32'(core_sleep_o));
    check_val("exit_valid_o", 32'(exp_exit_valid[t]), 32'(exit_valid_o));
    if (exp_exit_valid[t]) check_val("exit_value_o", exp_exit_value[t], exit_value_o);
    check_val("tests_passed_o", 32'(exp_passed[t]), 32'(tests_passed_o));
    check_val("tests_failed_o", 32'(exp_failed[t]), 32'(tests_failed_o));
    check_val("stdout_len", 32'(exp_stdout_len[t]), 32'(got_chars.size()));
    n = (got_chars.size() < exp_stdout_len[t]) ? got_chars.size() : exp_stdout_len[t];
    for (int i = 0; i < n; i++) begin
      check_val($sformatf("stdout_char_o[%0d]", i), 32'(exp_stdout[t][i]), 32'(got_chars[i]));
    end
  endtask

  initial begin
    int errs_before;
    int tests_ok;
    rst_n_i        = 1'b0;
    fetch_enable_i = 1'b0;
    load_we_i      = 1'b0;
    load_addr_i    = 32'h0;
    load_data_i    = 32'h0;
    tests_ok       = 0;
    build_table();

    for (int t = 0; t < NUM_TESTS; t++) begin
      errs_before = err_count;
      apply_reset();
      check_reset_state();
      got_chars.delete();
      load_program(t);
      @(posedge clk_i);
      fetch_enable_i <= 1'b1;
      do @(negedge clk_i); while (!core_sleep_o);
      // a couple of idle cycles show that nothing moves after sleep
      repeat (2) @(negedge clk_i);
      check_results(t);
      if (err_count == errs_before) begin
        tests_ok++;
        $display("test %0d %s: ok", t, test_name[t]);
      end else begin
        $display("test %0d %s: %0d errors", t, test_name[t], err_count - errs_before);
      end
    end

    $display("%0d tests run, %0d ok, %0d with errors, %0d check errors in total",
             NUM_TESTS, tests_ok, NUM_TESTS - tests_ok, err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* tb_subsystem.sv */
// Top level of the processor test subsystem.
// Connects the tiny core to the memory block with its pseudo-peripherals.
// A testbench loads a program through the loader port, raises
// fetch_enable_i and waits for core_sleep_o.

`timescale 1ns/1ps

module tb_subsystem import mem_map_pkg::*; #(
  parameter int                   RAM_ADDR_WIDTH = 12,
  parameter logic [BUS_WIDTH-1:0] BOOT_ADDR      = '0
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 fetch_enable_i,

  input  logic                 load_we_i,
  input  logic [BUS_WIDTH-1:0] load_addr_i,
  input  logic [BUS_WIDTH-1:0] load_data_i,

  output logic                 stdout_valid_o,
  output logic [7:0]           stdout_char_o,
  output logic                 exit_valid_o,
  output logic [BUS_WIDTH-1:0] exit_value_o,
  output logic                 tests_passed_o,
  output logic                 tests_failed_o,
  output logic                 core_sleep_o
);

  // instruction port between core and memory
  logic                 instr_req;
  logic                 instr_gnt;
  logic                 instr_rvalid;
  logic [BUS_WIDTH-1:0] instr_addr;
  logic [BUS_WIDTH-1:0] instr_rdata;

  // data port between core and memory
  logic                 data_req;
  logic                 data_gnt;
  logic                 data_rvalid;
  logic [BUS_WIDTH-1:0] data_addr;
  logic                 data_we;
  logic [BE_WIDTH-1:0]  data_be;
  logic [BUS_WIDTH-1:0] data_wdata;
  logic [BUS_WIDTH-1:0] data_rdata;

  tiny_core core_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fetch_enable_i(fetch_enable_i),
    .boot_addr_i   (BOOT_ADDR),
    .instr_req_o   (instr_req),
    .instr_addr_o  (instr_addr),
    .instr_gnt_i   (instr_gnt),
    .instr_rvalid_i(instr_rvalid),
    .instr_rdata_i (instr_rdata),
    .data_req_o    (data_req),
    .data_addr_o   (data_addr),
    .data_we_o     (data_we),
    .data_be_o     (data_be),
    .data_wdata_o  (data_wdata),
    .data_gnt_i    (data_gnt),
    .data_rvalid_i (data_rvalid),
    .data_rdata_i  (data_rdata),
    .core_sleep_o  (core_sleep_o)
  );

  mm_ram #(
    .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
  ) ram_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fetch_enable_i(fetch_enable_i),
    .load_we_i     (load_we_i),
    .load_addr_i   (load_addr_i),
    .load_data_i   (load_data_i),
    .instr_req_i   (instr_req),
    .instr_addr_i  (instr_addr),
    .instr_gnt_o   (instr_gnt),
    .instr_rvalid_o(instr_rvalid),
    .instr_rdata_o (instr_rdata),
    .data_req_i    (data_req),
    .data_addr_i   (data_addr),
    .data_we_i     (data_we),
    .data_be_i     (data_be),
    .data_wdata_i  (data_wdata),
    .data_gnt_o    (data_gnt),
    .data_rvalid_o (data_rvalid),
    .data_rdata_o  (data_rdata),
    .stdout_valid_o(stdout_valid_o),
    .stdout_char_o (stdout_char_o),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o),
    .tests_passed_o(tests_passed_o),
    .tests_failed_o(tests_failed_o)
  );

endmodule

/* mm_ram.sv */
// Memory block seen by the core.
// Routes data accesses to the RAM or to the stdout, exit-value and control
// pseudo-peripherals, and lets the loader port write RAM while fetch is off.

`timescale 1ns/1ps

module mm_ram import mem_map_pkg::*; #(
  parameter int RAM_ADDR_WIDTH = 12
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 fetch_enable_i,

  input  logic                 load_we_i,
  input  logic [BUS_WIDTH-1:0] load_addr_i,
  input  logic [BUS_WIDTH-1:0] load_data_i,

  input  logic                 instr_req_i,
  input  logic [BUS_WIDTH-1:0] instr_addr_i,
  output logic                 instr_gnt_o,
  output logic                 instr_rvalid_o,
  output logic [BUS_WIDTH-1:0] instr_rdata_o,

  input  logic                 data_req_i,
  input  logic [BUS_WIDTH-1:0] data_addr_i,
  input  logic                 data_we_i,
  input  logic [BE_WIDTH-1:0]  data_be_i,
  input  logic [BUS_WIDTH-1:0] data_wdata_i,
  output logic                 data_gnt_o,
  output logic                 data_rvalid_o,
  output logic [BUS_WIDTH-1:0] data_rdata_o,

  output logic                 stdout_valid_o,
  output logic [7:0]           stdout_char_o,
  output logic                 exit_valid_o,
  output logic [BUS_WIDTH-1:0] exit_value_o,
  output logic                 tests_passed_o,
  output logic                 tests_failed_o
);

  logic                 data_ram_req;
  logic                 data_periph_req;
  logic                 periph_wr;
  logic                 ram_pending_q;
  logic                 periph_pending_q;

  logic                 b_req;
  logic [BUS_WIDTH-1:0] b_addr;
  logic                 b_we;
  logic [BE_WIDTH-1:0]  b_be;
  logic [BUS_WIDTH-1:0] b_wdata;
  logic                 b_gnt;
  logic                 b_rvalid;
  logic [BUS_WIDTH-1:0] b_rdata;

  // the loader owns port b until fetch is enabled
  assign data_ram_req    = fetch_enable_i && data_req_i && is_ram_addr(data_addr_i);
  assign data_periph_req = data_req_i && !is_ram_addr(data_addr_i);
  assign periph_wr       = data_periph_req && data_we_i;

  assign b_req   = fetch_enable_i ? data_ram_req : load_we_i;
  assign b_addr  = fetch_enable_i ? data_addr_i : load_addr_i;
  assign b_we    = fetch_enable_i ? data_we_i : 1'b1;
  assign b_be    = fetch_enable_i ? data_be_i : '1;
  assign b_wdata = fetch_enable_i ? data_wdata_i : load_data_i;

  assign data_gnt_o    = data_ram_req ? b_gnt : data_periph_req;
  assign data_rvalid_o = (ram_pending_q && b_rvalid) || periph_pending_q;
  // peripheral reads return zero
  assign data_rdata_o  = ram_pending_q ? b_rdata : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ram_pending_q    <= 1'b0;
      periph_pending_q <= 1'b0;
      stdout_valid_o   <= 1'b0;
      stdout_char_o    <= '0;
      exit_valid_o     <= 1'b0;
      exit_value_o     <= '0;
      tests_passed_o   <= 1'b0;
      tests_failed_o   <= 1'b0;
    end else begin
      ram_pending_q    <= data_ram_req;
      periph_pending_q <= data_periph_req;
      stdout_valid_o   <= periph_wr && (data_addr_i == STDOUT_ADDR);
      if (periph_wr && data_addr_i == STDOUT_ADDR) begin
        stdout_char_o <= data_wdata_i[7:0];
      end
      if (periph_wr && data_addr_i == EXIT_VALUE_ADDR) begin
        exit_value_o <= data_wdata_i;
        exit_valid_o <= 1'b1;
      end
      if (periph_wr && data_addr_i == CTRL_ADDR) begin
        if (data_wdata_i == PASS_MAGIC) tests_passed_o <= 1'b1;
        if (data_wdata_i == FAIL_CODE)  tests_failed_o <= 1'b1;
      end
    end
  end

  dp_ram #(
    .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
  ) ram_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .a_req_i   (instr_req_i),
    .a_addr_i  (instr_addr_i),
    .a_gnt_o   (instr_gnt_o),
    .a_rvalid_o(instr_rvalid_o),
    .a_rdata_o (instr_rdata_o),
    .b_req_i   (b_req),
    .b_addr_i  (b_addr),
    .b_we_i    (b_we),
    .b_be_i    (b_be),
    .b_wdata_i (b_wdata),
    .b_gnt_o   (b_gnt),
    .b_rvalid_o(b_rvalid),
    .b_rdata_o (b_rdata)
  );

  // a program reports either a pass or a fail and never both
  a_one_verdict: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(tests_passed_o && tests_failed_o));

endmodule

/* dp_ram.sv */
// Dual-port word RAM with byte enables.
// Port a is read-only and serves instruction fetches, port b reads and
// writes. Both grant in the request cycle and answer one cycle later.

`timescale 1ns/1ps

module dp_ram import mem_map_pkg::*; #(
  parameter int RAM_ADDR_WIDTH = 12
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  input  logic                 a_req_i,
  input  logic [BUS_WIDTH-1:0] a_addr_i,
  output logic                 a_gnt_o,
  output logic                 a_rvalid_o,
  output logic [BUS_WIDTH-1:0] a_rdata_o,

  input  logic                 b_req_i,
  input  logic [BUS_WIDTH-1:0] b_addr_i,
  input  logic                 b_we_i,
  input  logic [BE_WIDTH-1:0]  b_be_i,
  input  logic [BUS_WIDTH-1:0] b_wdata_i,
  output logic                 b_gnt_o,
  output logic                 b_rvalid_o,
  output logic [BUS_WIDTH-1:0] b_rdata_o
);

  localparam int NUM_WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

  logic [BUS_WIDTH-1:0]      mem [NUM_WORDS];
  logic [RAM_ADDR_WIDTH-3:0] a_idx;
  logic [RAM_ADDR_WIDTH-3:0] b_idx;

  assign a_idx = a_addr_i[RAM_ADDR_WIDTH-1:2];
  assign b_idx = b_addr_i[RAM_ADDR_WIDTH-1:2];

  // there is no back-pressure and every request is granted in its own cycle
  assign a_gnt_o = a_req_i;
  assign b_gnt_o = b_req_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_rvalid_o <= 1'b0;
      b_rvalid_o <= 1'b0;
    end else begin
      a_rvalid_o <= a_req_i;
      b_rvalid_o <= b_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_req_i) begin
      a_rdata_o <= mem[a_idx];
    end
    if (b_req_i) begin
      if (b_we_i) begin
        for (int i = 0; i < BE_WIDTH; i++) begin
          if (b_be_i[i]) mem[b_idx][8*i +: 8] <= b_wdata_i[8*i +: 8];
        end
      end else begin
        b_rdata_o <= mem[b_idx];
      end
    end
  end

  // upper address bits are dropped by the index, so they must be zero
  a_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (a_req_i |-> (a_addr_i >> RAM_ADDR_WIDTH) == '0) and
    (b_req_i |-> (b_addr_i >> RAM_ADDR_WIDTH) == '0));

endmodule

/* tiny_core.sv */
// Minimal multi-cycle 32-bit load/store core.
// Fetches on the instruction port and loads or stores on the data port,
// both with the req/gnt/rvalid handshake. Starts at boot_addr_i once
// fetch_enable_i is seen and sleeps on OP_HALT or an illegal opcode.

`timescale 1ns/1ps

module tiny_core import tiny_isa_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,

  input  logic            fetch_enable_i,
  input  logic [XLEN-1:0] boot_addr_i,

  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,

  output logic            data_req_o,
  output logic [XLEN-1:0] data_addr_o,
  output logic            data_we_o,
  output logic [3:0]      data_be_o,
  output logic [XLEN-1:0] data_wdata_o,
  input  logic            data_gnt_i,
  input  logic            data_rvalid_i,
  input  logic [XLEN-1:0] data_rdata_i,

  output logic            core_sleep_o
);

  core_state_e       state_q;
  logic [XLEN-1:0]   pc_q;
  logic [XLEN-1:0]   instr_q;
  logic [XLEN-1:0]   regs [NUM_REGS];

  logic [XLEN-1:0]   addr_q;
  logic [XLEN-1:0]   wdata_q;
  logic [3:0]        be_q;
  logic              we_q;

  opcode_e           opcode;
  logic [REG_AW-1:0] rd;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [XLEN-1:0]   imm_sx;
  logic [XLEN-1:0]   rs1_val;
  logic [XLEN-1:0]   rs2_val;
  logic [XLEN-1:0]   rd_val;
  logic [XLEN-1:0]   mem_addr;
  logic [XLEN-1:0]   alu_res;
  logic              alu_wr;
  logic              br_taken;
  logic [XLEN-1:0]   pc_next;

  assign opcode = opcode_e'(instr_q[OPC_MSB:OPC_LSB]);
  assign rd     = instr_q[RD_MSB:RD_LSB];
  assign rs1    = instr_q[RS1_MSB:RS1_LSB];
  assign rs2    = instr_q[RS2_MSB:RS2_LSB];
  assign imm_sx = {{(XLEN-16){instr_q[IMM_MSB]}}, instr_q[IMM_MSB:IMM_LSB]};

  // register 0 is hardwired to zero on every read port
  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];
  // stores take their data register from the rd field
  assign rd_val  = (rd == '0) ? '0 : regs[rd];

  assign mem_addr = rs1_val + imm_sx;

  always_comb begin
    alu_res  = '0;
    alu_wr   = 1'b1;
    br_taken = 1'b0;
    case (opcode)
      OP_LI:   alu_res = imm_sx;
      OP_ADDI: alu_res = rs1_val + imm_sx;
      OP_ADD:  alu_res = rs1_val + rs2_val;
      OP_SUB:  alu_res = rs1_val - rs2_val;
      OP_AND:  alu_res = rs1_val & rs2_val;
      OP_OR:   alu_res = rs1_val | rs2_val;
      OP_XOR:  alu_res = rs1_val ^ rs2_val;
      OP_BEQ: begin
        alu_wr   = 1'b0;
        br_taken = (rs1_val == rs2_val);
      end
      OP_BNE: begin
        alu_wr   = 1'b0;
        br_taken = (rs1_val != rs2_val);
      end
      default: alu_wr = 1'b0;
    endcase
  end

  // branch offsets count words from the branch itself
  assign pc_next = br_taken ? pc_q + {imm_sx[XLEN-3:0], 2'b00} : pc_q + 32'd4;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      pc_q    <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (fetch_enable_i) begin
            pc_q    <= boot_addr_i;
            state_q <= S_FETCH;
          end
        end
        S_FETCH: if (instr_gnt_i) state_q <= S_FWAIT;
        S_FWAIT: if (instr_rvalid_i) state_q <= S_EXEC;
        S_EXEC: begin
          case (opcode)
            OP_LI, OP_ADDI, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
            OP_BEQ, OP_BNE: begin
              pc_q    <= pc_next;
              state_q <= S_FETCH;
            end
            OP_LW, OP_SW, OP_SB: begin
              pc_q    <= pc_next;
              state_q <= S_MEM;
            end
            default: state_q <= S_SLEEP;
          endcase
        end
        S_MEM:   if (data_gnt_i) state_q <= S_MWAIT;
        S_MWAIT: if (data_rvalid_i) state_q <= S_FETCH;
        default: state_q <= S_SLEEP;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_FWAIT && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
    if (state_q == S_EXEC) begin
      addr_q <= mem_addr;
      we_q   <= (opcode != OP_LW);
      if (opcode == OP_SB) begin
        be_q    <= 4'b0001 << mem_addr[1:0];
        wdata_q <= {24'b0, rd_val[7:0]} << {mem_addr[1:0], 3'b000};
      end else begin
        be_q    <= 4'b1111;
        wdata_q <= rd_val;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == S_EXEC && alu_wr && rd != '0) begin
      regs[rd] <= alu_res;
    end else if (state_q == S_MWAIT && data_rvalid_i && !we_q && rd != '0) begin
      regs[rd] <= data_rdata_i;
    end
  end

  assign instr_req_o  = (state_q == S_FETCH);
  assign instr_addr_o = pc_q;

  assign data_req_o   = (state_q == S_MEM);
  assign data_addr_o  = addr_q;
  assign data_we_o    = we_q;
  assign data_be_o    = be_q;
  assign data_wdata_o = wdata_q;

  assign core_sleep_o = (state_q == S_SLEEP);

  // a pending request keeps its address until the memory grants it
  a_instr_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  a_data_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o));

  // once asleep the core never touches either port again
  a_sleep_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    core_sleep_o |=> core_sleep_o && !instr_req_o && !data_req_o);

endmodule

/* mem_map_pkg.sv */
// Memory map of the test subsystem.
// Gives the pseudo-peripheral addresses, the control word values and the
// bus widths used by the RAM, the address decoder, the top level and the
// testbench.

package mem_map_pkg;

  localparam int BUS_WIDTH = 32;
  localparam int BE_WIDTH  = BUS_WIDTH / 8;

  // any address with a zero top nibble goes to RAM
  localparam logic [3:0] RAM_REGION = 4'h0;

  localparam logic [BUS_WIDTH-1:0] STDOUT_ADDR     = 32'h1000_0000;
  localparam logic [BUS_WIDTH-1:0] EXIT_VALUE_ADDR = 32'h2000_0000;
  localparam logic [BUS_WIDTH-1:0] CTRL_ADDR       = 32'h2000_0004;

  // only these two values have an effect when written to CTRL_ADDR
  localparam logic [BUS_WIDTH-1:0] PASS_MAGIC = 32'h075B_CD15;
  localparam logic [BUS_WIDTH-1:0] FAIL_CODE  = 32'h0000_0001;

  function automatic logic is_ram_addr(input logic [BUS_WIDTH-1:0] addr);
    return addr[BUS_WIDTH-1 -: 4] == RAM_REGION;
  endfunction

endpackage

/* tiny_isa_pkg.sv */
// Instruction set of the tiny load/store core.
// Holds the opcode and state encodings, the fixed instruction field
// positions and the register file size. Imported by the core, and by the
// testbench to encode its programs.

package tiny_isa_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 16;
  localparam int REG_AW   = 4;

  // field positions inside a 32-bit instruction word
  localparam int OPC_MSB = 31;
  localparam int OPC_LSB = 28;
  localparam int RD_MSB  = 27;
  localparam int RD_LSB  = 24;
  localparam int RS1_MSB = 23;
  localparam int RS1_LSB = 20;
  localparam int RS2_MSB = 19;
  localparam int RS2_LSB = 16;
  localparam int IMM_MSB = 15;
  localparam int IMM_LSB = 0;

  // encodings 13 to 15 are illegal and put the core to sleep
  typedef enum logic [3:0] {
    OP_HALT = 4'd0,
    OP_LI   = 4'd1,
    OP_ADDI = 4'd2,
    OP_ADD  = 4'd3,
    OP_SUB  = 4'd4,
    OP_AND  = 4'd5,
    OP_OR   = 4'd6,
    OP_XOR  = 4'd7,
    OP_LW   = 4'd8,
    OP_SW   = 4'd9,
    OP_SB   = 4'd10,
    OP_BEQ  = 4'd11,
    OP_BNE  = 4'd12
  } opcode_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_FWAIT,
    S_EXEC,
    S_MEM,
    S_MWAIT,
    S_SLEEP
  } core_state_e;

endpackage
